/* rtl/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  logic                valid,
    input  logic [31:0]         pc,
    input  logic [31:0]         inst,
    input  logic                if_have_exception,
    input  isa_pkg::exception_t if_exception_type,
    input  logic                if_pred_branch_taken,
    input  logic [31:0]         if_pred_branch_target,
    input  logic [63:0]         counter,
    output pipe_pkg::decoded_t  info
);
    import isa_pkg::*;

    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [31:0] si12;
    logic [31:0] offs16;
    logic [31:0] offs26;
    logic        is_add, is_sub, is_addi, is_lui, is_ld, is_st;
    logic        is_beq, is_bne, is_b, is_bl, is_jirl;
    logic        is_csrrd, is_cntvl, is_cntvh;
    logic        matched;
    logic        uncond;

    assign rd     = inst[4:0];
    assign rj     = inst[9:5];
    assign rk     = inst[14:10];
    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    assign is_add   = (inst & R3_MASK) == ADD_W_MATCH;
    assign is_sub   = (inst & R3_MASK) == SUB_W_MATCH;
    assign is_addi  = (inst & I12_MASK) == ADDI_W_MATCH;
    assign is_lui   = (inst & LU12I_W_MASK) == LU12I_W_MATCH;
    assign is_ld    = (inst & I12_MASK) == LD_W_MATCH;
    assign is_st    = (inst & I12_MASK) == ST_W_MATCH;
    assign is_beq   = (inst & BRANCH_MASK) == BEQ_MATCH;
    assign is_bne   = (inst & BRANCH_MASK) == BNE_MATCH;
    assign is_b     = (inst & BRANCH_MASK) == B_MATCH;
    assign is_bl    = (inst & BRANCH_MASK) == BL_MATCH;
    assign is_jirl  = (inst & BRANCH_MASK) == JIRL_MATCH;
    assign is_csrrd = (inst & CSRRD_MASK) == CSRRD_MATCH;
    assign is_cntvl = (inst & RDCNT_MASK) == RDCNTVL_MATCH;
    assign is_cntvh = (inst & RDCNT_MASK) == RDCNTVH_MATCH;

    assign matched = |{is_add, is_sub, is_addi, is_lui, is_ld, is_st, is_beq, is_bne,
                       is_b, is_bl, is_jirl, is_csrrd, is_cntvl, is_cntvh};
    assign uncond  = is_b || is_bl || is_jirl;

    always_comb begin
        info                    = '0;
        info.pc                 = pc;
        info.pred_branch_taken  = if_pred_branch_taken;
        info.pred_branch_target = if_pred_branch_target;

        if (is_add || is_sub) begin
            info.opcode  = is_sub ? OP_SUB : OP_ADD;
            info.rf_src1 = rj;
            info.rf_src2 = rk;
            info.dest    = rd;
        end else if (is_addi || is_cntvl || is_cntvh) begin
            info.opcode      = OP_ADD;
            info.rf_src1     = is_addi ? rj : 5'd0;    // Counter reads add to r0
            info.src2_is_imm = 1'b1;
            info.imm         = is_addi ? si12 : is_cntvl ? counter[31:0] : counter[63:32];
            info.dest        = rd;
        end else if (is_lui) begin
            info.opcode      = OP_LUI;
            info.src2_is_imm = 1'b1;
            info.imm         = {inst[24:5], 12'h000};
            info.dest        = rd;
        end else if (is_ld || is_st) begin
            info.opcode      = is_ld ? OP_LOAD : OP_STORE;
            info.rf_src1     = rj;
            info.rf_src2     = is_st ? rd : 5'd0;      // Store data
            info.src2_is_imm = is_ld;
            info.imm         = si12;
            info.dest        = is_ld ? rd : 5'd0;
            info.mem_type    = is_ld ? MEM_LOAD_S : MEM_STORE;
            info.mem_size    = SIZE_WORD;
        end else if (is_beq || is_bne) begin
            info.opcode           = is_beq ? OP_BEQ : OP_BNE;
            info.rf_src1          = rj;
            info.rf_src2          = rd;
            info.imm              = offs16;
            info.is_branch        = 1'b1;
            info.branch_condition = 1'b1;
            info.branch_target    = pc + offs16;
        end else if (uncond) begin
            info.opcode        = is_b ? OP_B : is_bl ? OP_BL : OP_JIRL;
            info.rf_src1       = is_jirl ? rj : 5'd0;
            info.imm           = is_jirl ? offs16 : offs26;
            info.dest          = is_bl ? 5'd1 : is_jirl ? rd : 5'd0;
            info.is_branch     = 1'b1;
            info.branch_taken  = 1'b1;
            info.is_jirl       = is_jirl;
            // jirl target needs rj, so only the offset is known here
            info.branch_target = is_jirl ? offs16 : pc + offs26;
        end else if (is_csrrd) begin
            info.opcode      = OP_SPEC;
            info.src2_is_imm = 1'b1;
            info.imm         = {18'd0, inst[23:10]};   // CSR number
            info.dest        = rd;
            info.is_spec_op  = 1'b1;
            info.spec_opcode = SPEC_CSRRD;
        end

        info.have_exception = if_have_exception || (valid && !matched);
        info.exception_type = if_have_exception   ? if_exception_type :
                              info.have_exception ? EXC_INE : EXC_NONE;

        // ########################################
        // Misprediction at decode
        // ########################################
        info.branch_mistaken = valid && (
            (uncond && !if_pred_branch_taken) ||
            ((is_b || is_bl) && if_pred_branch_taken &&
             if_pred_branch_target != info.branch_target) ||
            (!info.is_branch && if_pred_branch_taken));
    end

endmodule

/* rtl/fetch_slot_if.sv */
`timescale 1ns/1ps

interface fetch_slot_if;
    import isa_pkg::*;

    logic                valid;
    logic [31:0]         pc;
    logic [31:0]         inst;
    logic                pred_branch_taken;
    logic [31:0]         pred_branch_target;
    logic                have_exception;
    exception_t          exception_type;

    modport queue  (output valid, pc, inst, pred_branch_taken, pred_branch_target,
                    have_exception, exception_type);
    modport decode (input  valid, pc, inst, pred_branch_taken, pred_branch_target,
                    have_exception, exception_type);

endinterface

/* rtl/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic               ro_stall,
    input  logic [63:0]        counter,

    fetch_slot_if.decode       slot_a,
    fetch_slot_if.decode       slot_b,

    output logic [1:0]         id_consume_inst,
    output logic               id_a_ready,
    output pipe_pkg::decoded_t id_a,
    output logic               id_b_ready,
    output pipe_pkg::decoded_t id_b
);
    import pipe_pkg::*;
    import isa_pkg::*;

    decoded_t a_info;
    decoded_t b_info;
    logic     raw_hazard;

    decoder decoder_a (
        .valid                 (slot_a.valid),
        .pc                    (slot_a.pc),
        .inst                  (slot_a.inst),
        .if_have_exception     (slot_a.have_exception),
        .if_exception_type     (slot_a.exception_type),
        .if_pred_branch_taken  (slot_a.pred_branch_taken),
        .if_pred_branch_target (slot_a.pred_branch_target),
        .counter               (counter),
        .info                  (a_info)
    );

    decoder decoder_b (
        .valid                 (slot_b.valid),
        .pc                    (slot_b.pc),
        .inst                  (slot_b.inst),
        .if_have_exception     (slot_b.have_exception),
        .if_exception_type     (slot_b.exception_type),
        .if_pred_branch_taken  (slot_b.pred_branch_taken),
        .if_pred_branch_target (slot_b.pred_branch_target),
        .counter               (counter),
        .info                  (b_info)
    );

    // b reads what a writes in the same pair
    assign raw_hazard = slot_a.valid && slot_b.valid && a_info.dest != 5'd0 &&
                        (a_info.dest == b_info.rf_src1 || a_info.dest == b_info.rf_src2);

    assign id_a_ready = slot_a.valid;
    assign id_b_ready = slot_b.valid && id_a_ready && !a_info.is_spec_op &&
                        !raw_hazard && b_info.mem_type == MEM_NOP;

    assign id_consume_inst = ro_stall   ? 2'd0 :
                             id_b_ready ? 2'd2 :
                             id_a_ready ? 2'd1 :
                                          2'd0;

    always_comb begin
        id_a                 = a_info;
        id_b                 = b_info;
        id_a.branch_mistaken = a_info.branch_mistaken && !ro_stall;
        id_b.branch_mistaken = b_info.branch_mistaken && !ro_stall;
    end

endmodule

/* rtl/id_top.sv */
`timescale 1ns/1ps

module id_top (
    input  logic                clk,
    input  logic                reset,
    input  logic [63:0]         counter,
    input  logic                ro_stall,

    input  logic                push_valid,
    input  logic [31:0]         push_pc,
    input  logic [31:0]         push_inst,
    input  logic                push_pred_branch_taken,
    input  logic [31:0]         push_pred_branch_target,
    input  logic                push_have_exception,
    input  isa_pkg::exception_t push_exception_type,
    output logic                fetch_full,

    output logic                ro_a_valid,
    output pipe_pkg::decoded_t  ro_a,
    output logic                ro_b_valid,
    output pipe_pkg::decoded_t  ro_b
);
    import pipe_pkg::*;

    logic [1:0] id_consume_inst;
    logic       id_a_ready;
    logic       id_b_ready;
    decoded_t   id_a;
    decoded_t   id_b;

    fetch_slot_if slot_a ();    // Oldest entry
    fetch_slot_if slot_b ();

    inst_queue inst_queue_inst (
        .clk                     (clk),
        .reset                   (reset),
        .push_valid              (push_valid),
        .push_pc                 (push_pc),
        .push_inst               (push_inst),
        .push_pred_branch_taken  (push_pred_branch_taken),
        .push_pred_branch_target (push_pred_branch_target),
        .push_have_exception     (push_have_exception),
        .push_exception_type     (push_exception_type),
        .fetch_full              (fetch_full),
        .consume                 (id_consume_inst),
        .slot_a                  (slot_a),
        .slot_b                  (slot_b)
    );

    id_stage id_stage_inst (
        .ro_stall        (ro_stall),
        .counter         (counter),
        .slot_a          (slot_a),
        .slot_b          (slot_b),
        .id_consume_inst (id_consume_inst),
        .id_a_ready      (id_a_ready),
        .id_a            (id_a),
        .id_b_ready      (id_b_ready),
        .id_b            (id_b)
    );

    issue_reg issue_reg_inst (
        .clk        (clk),
        .reset      (reset),
        .ro_stall   (ro_stall),
        .id_a_ready (id_a_ready),
        .id_a       (id_a),
        .id_b_ready (id_b_ready),
        .id_b       (id_b),
        .ro_a_valid (ro_a_valid),
        .ro_a       (ro_a),
        .ro_b_valid (ro_b_valid),
        .ro_b       (ro_b)
    );

endmodule

/* rtl/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue (
    input  logic                clk,
    input  logic                reset,

    input  logic                push_valid,
    input  logic [31:0]         push_pc,
    input  logic [31:0]         push_inst,
    input  logic                push_pred_branch_taken,
    input  logic [31:0]         push_pred_branch_target,
    input  logic                push_have_exception,
    input  isa_pkg::exception_t push_exception_type,
    output logic                fetch_full,

    input  logic [1:0]          consume,
    fetch_slot_if.queue         slot_a,
    fetch_slot_if.queue         slot_b
);
    import pipe_pkg::*;
    import isa_pkg::*;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        pred_branch_taken;
        logic [31:0] pred_branch_target;
        logic        have_exception;
        exception_t  exception_type;
    } entry_t;

    entry_t                 mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] head;
    logic [QUEUE_PTR_W-1:0] tail;
    logic [QUEUE_PTR_W-1:0] head_next;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   push_ok;
    entry_t                 entry_a;
    entry_t                 entry_b;

    assign fetch_full = count >= QUEUE_CNT_W'(QUEUE_DEPTH - 1);
    assign push_ok    = push_valid && !fetch_full;    // Overflow push is dropped
    assign head_next  = head + QUEUE_PTR_W'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + QUEUE_PTR_W'(consume);
            if (push_ok)
                tail <= tail + QUEUE_PTR_W'(1);
            count <= count + QUEUE_CNT_W'(push_ok) - QUEUE_CNT_W'(consume);
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok)
            mem[tail] <= '{push_pc, push_inst, push_pred_branch_taken,
                           push_pred_branch_target, push_have_exception,
                           push_exception_type};
    end

    // ########################################
    // Head slots toward decode
    // ########################################

    assign entry_a = mem[head];
    assign entry_b = mem[head_next];

    assign slot_a.valid              = count != '0;
    assign slot_a.pc                 = entry_a.pc;
    assign slot_a.inst               = entry_a.inst;
    assign slot_a.pred_branch_taken  = entry_a.pred_branch_taken;
    assign slot_a.pred_branch_target = entry_a.pred_branch_target;
    assign slot_a.have_exception     = entry_a.have_exception;
    assign slot_a.exception_type     = entry_a.exception_type;

    assign slot_b.valid              = count > QUEUE_CNT_W'(1);
    assign slot_b.pc                 = entry_b.pc;
    assign slot_b.inst               = entry_b.inst;
    assign slot_b.pred_branch_taken  = entry_b.pred_branch_taken;
    assign slot_b.pred_branch_target = entry_b.pred_branch_target;
    assign slot_b.have_exception     = entry_b.have_exception;
    assign slot_b.exception_type     = entry_b.exception_type;

endmodule

/* rtl/isa_pkg.sv */
package isa_pkg;

    // ########################################
    // Enumerations
    // ########################################

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_ADEF = 2'd1,    // Fetch address error
        EXC_INE  = 2'd2     // Invalid instruction
    } exception_t;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_LUI, OP_LOAD, OP_STORE, OP_BEQ,
        OP_BNE, OP_B, OP_BL, OP_JIRL, OP_SPEC
    } opcode_t;

    typedef enum logic [1:0] {
        MEM_NOP, MEM_LOAD_S, MEM_LOAD_U, MEM_STORE
    } mem_type_t;

    typedef enum logic [1:0] {
        SIZE_BYTE, SIZE_HALF, SIZE_WORD
    } mem_size_t;

    typedef enum logic [1:0] {
        SPEC_NONE, SPEC_CSRRD
    } spec_opcode_t;

    // ########################################
    // Encoding match and mask
    // ########################################

    localparam logic [31:0] ADD_W_MATCH   = 32'h0010_0000;
    localparam logic [31:0] SUB_W_MATCH   = 32'h0011_0000;
    localparam logic [31:0] R3_MASK       = 32'hffff_8000;   // add.w, sub.w
    localparam logic [31:0] ADDI_W_MATCH  = 32'h0280_0000;
    localparam logic [31:0] LD_W_MATCH    = 32'h2880_0000;
    localparam logic [31:0] ST_W_MATCH    = 32'h2980_0000;
    localparam logic [31:0] I12_MASK      = 32'hffc0_0000;
    localparam logic [31:0] LU12I_W_MATCH = 32'h1400_0000;
    localparam logic [31:0] LU12I_W_MASK  = 32'hfe00_0000;
    localparam logic [31:0] BEQ_MATCH     = 32'h5800_0000;
    localparam logic [31:0] BNE_MATCH     = 32'h5c00_0000;
    localparam logic [31:0] B_MATCH       = 32'h5000_0000;
    localparam logic [31:0] BL_MATCH      = 32'h5400_0000;
    localparam logic [31:0] JIRL_MATCH    = 32'h4c00_0000;
    localparam logic [31:0] BRANCH_MASK   = 32'hfc00_0000;
    localparam logic [31:0] CSRRD_MATCH   = 32'h0400_0000;
    localparam logic [31:0] CSRRD_MASK    = 32'hff00_03e0;   // rj must be zero
    localparam logic [31:0] RDCNTVL_MATCH = 32'h0000_6000;
    localparam logic [31:0] RDCNTVH_MATCH = 32'h0000_6400;
    localparam logic [31:0] RDCNT_MASK    = 32'hffff_ffe0;

endpackage

/* rtl/issue_reg.sv */
`timescale 1ns/1ps

module issue_reg (
    input  logic               clk,
    input  logic               reset,
    input  logic               ro_stall,

    input  logic               id_a_ready,
    input  pipe_pkg::decoded_t id_a,
    input  logic               id_b_ready,
    input  pipe_pkg::decoded_t id_b,

    output logic               ro_a_valid,
    output pipe_pkg::decoded_t ro_a,
    output logic               ro_b_valid,
    output pipe_pkg::decoded_t ro_b
);

    always_ff @(posedge clk) begin
        if (reset) begin
            ro_a_valid <= 1'b0;
            ro_b_valid <= 1'b0;
        end else if (!ro_stall) begin
            ro_a_valid <= id_a_ready;
            ro_b_valid <= id_b_ready;
        end
    end

    // Payload follows the valids, frozen under stall
    always_ff @(posedge clk) begin
        if (!ro_stall) begin
            ro_a <= id_a;
            ro_b <= id_b;
        end
    end

endmodule

/* rtl/pipe_pkg.sv */
package pipe_pkg;

    localparam int QUEUE_DEPTH  = 8;
    localparam int QUEUE_PTR_W  = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W  = $clog2(QUEUE_DEPTH + 1);

    // One decoded instruction as it leaves decode
    typedef struct packed {
        logic [31:0]           pc;
        logic                  have_exception;
        isa_pkg::exception_t   exception_type;
        isa_pkg::opcode_t      opcode;
        logic [4:0]            rf_src1;
        logic [4:0]            rf_src2;
        logic                  src2_is_imm;
        logic [31:0]           imm;
        logic [4:0]            dest;
        logic                  is_branch;
        logic                  branch_taken;
        logic                  branch_condition;    // Conditional, resolved later
        logic [31:0]           branch_target;       // Offset only for jirl
        logic                  is_jirl;
        logic                  pred_branch_taken;
        logic [31:0]           pred_branch_target;
        logic                  branch_mistaken;
        isa_pkg::mem_type_t    mem_type;
        isa_pkg::mem_size_t    mem_size;
        logic                  is_spec_op;
        isa_pkg::spec_opcode_t spec_opcode;
    } decoded_t;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_id_top -f sim.f -o tb_id_top

out=$(./obj_dir/tb_id_top)
echo "$out"

# Pass only when the testbench reported a pass
echo "$out" | grep -q "SIMULATION PASSED"

/* sim.f */
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_slot_if.sv
rtl/inst_queue.sv
rtl/decoder.sv
rtl/id_stage.sv
rtl/issue_reg.sv
rtl/id_top.sv
tests/tb_clock.sv
tests/tb_id_top.sv

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;    // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;           // Released on the stimulus offset
    end

endmodule

/* tests/tb_id_top.sv */
`timescale 1ns/1ps

module tb_id_top;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam logic [63:0] COUNTER_VALUE = 64'h0123_4567_89ab_cdef;

    logic        clk;
    logic        reset;
    logic [63:0] counter;
    logic        ro_stall;
    logic        push_valid;
    logic [31:0] push_pc;
    logic [31:0] push_inst;
    logic        push_pred_branch_taken;
    logic [31:0] push_pred_branch_target;
    logic        push_have_exception;
    exception_t  push_exception_type;
    logic        fetch_full;
    logic        ro_a_valid;
    decoded_t    ro_a;
    logic        ro_b_valid;
    decoded_t    ro_b;

    decoded_t    exp_q[$];
    decoded_t    exp_a;
    logic        pair;
    logic        loaded = 1'b0;
    logic [31:0] rng = 32'hc65746f7;
    logic [31:0] next_pc = 32'h1c00_0000;
    int          checks = 0;
    int          errors = 0;
    int          mark_checks = 0;
    int          mark_errors = 0;
    int          batch_count = 0;
    int          total_pushed = 0;
    int          cycles = 0;

    tb_clock tb_clock_inst (.clk(clk), .reset(reset));

    id_top id_top_inst (.*);

    // ########################################
    // Stimulus helpers
    // ########################################

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // Fields above rj sit at bit 10, rj at 9:5, rd at 4:0
    function automatic logic [31:0] encode(input logic [31:0] match, input logic [15:0] hi,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return match | {6'd0, hi, rj, rd};
    endfunction

    function automatic logic [31:0] rand_inst(input logic [31:0] r);
        case (r[2:0])
            3'd0:    return encode(ADD_W_MATCH, {11'd0, r[7:3]}, r[12:8], r[17:13]);
            3'd1:    return encode(SUB_W_MATCH, {11'd0, r[7:3]}, r[12:8], r[17:13]);
            3'd2:    return encode(ADDI_W_MATCH, {4'd0, r[31:20]}, r[12:8], r[17:13]);
            3'd3:    return LU12I_W_MATCH | {7'd0, r[31:12], r[8:4]};
            3'd4:    return encode(LD_W_MATCH, {4'd0, r[31:20]}, r[12:8], r[17:13]);
            3'd5:    return encode(ST_W_MATCH, {4'd0, r[31:20]}, r[12:8], r[17:13]);
            3'd6:    return encode(BNE_MATCH, r[31:16], r[12:8], r[7:3]);
            default: return {8'hff, r[23:0]};    // No such encoding
        endcase
    endfunction

    // ########################################
    // Reference model
    // ########################################

    function automatic decoded_t decode_ref(input logic [31:0] pc, input logic [31:0] inst,
                                            input logic pt, input logic [31:0] ptgt,
                                            input logic fetch_exc);
        decoded_t    d;
        logic [31:0] si12;
        logic [31:0] offs16;
        logic [31:0] offs26;
        logic        uncond;
        si12   = 32'(signed'(inst[21:10]));
        offs16 = 32'(signed'(inst[25:10])) << 2;
        offs26 = 32'(signed'({inst[9:0], inst[25:10]})) << 2;
        d                    = '0;
        d.pc                 = pc;
        d.pred_branch_taken  = pt;
        d.pred_branch_target = ptgt;
        d.have_exception     = fetch_exc;
        d.exception_type     = fetch_exc ? EXC_ADEF : EXC_NONE;
        if ((inst & R3_MASK) == ADD_W_MATCH || (inst & R3_MASK) == SUB_W_MATCH) begin
            d.opcode  = inst[16] ? OP_SUB : OP_ADD;
            d.rf_src1 = inst[9:5];
            d.rf_src2 = inst[14:10];
            d.dest    = inst[4:0];
        end else if ((inst & I12_MASK) == ADDI_W_MATCH) begin
            d.opcode      = OP_ADD;
            d.rf_src1     = inst[9:5];
            d.src2_is_imm = 1'b1;
            d.imm         = si12;
            d.dest        = inst[4:0];
        end else if ((inst & RDCNT_MASK) == RDCNTVL_MATCH ||
                     (inst & RDCNT_MASK) == RDCNTVH_MATCH) begin
            d.opcode      = OP_ADD;
            d.src2_is_imm = 1'b1;
            d.imm         = inst[10] ? COUNTER_VALUE[63:32] : COUNTER_VALUE[31:0];
            d.dest        = inst[4:0];
        end else if ((inst & LU12I_W_MASK) == LU12I_W_MATCH) begin
            d.opcode      = OP_LUI;
            d.src2_is_imm = 1'b1;
            d.imm         = 32'(inst[24:5]) << 12;
            d.dest        = inst[4:0];
        end else if ((inst & I12_MASK) == LD_W_MATCH) begin
            d.opcode      = OP_LOAD;
            d.rf_src1     = inst[9:5];
            d.src2_is_imm = 1'b1;
            d.imm         = si12;
            d.dest        = inst[4:0];
            d.mem_type    = MEM_LOAD_S;
            d.mem_size    = SIZE_WORD;
        end else if ((inst & I12_MASK) == ST_W_MATCH) begin
            d.opcode   = OP_STORE;
            d.rf_src1  = inst[9:5];
            d.rf_src2  = inst[4:0];
            d.imm      = si12;
            d.mem_type = MEM_STORE;
            d.mem_size = SIZE_WORD;
        end else if ((inst & BRANCH_MASK) == BEQ_MATCH || (inst & BRANCH_MASK) == BNE_MATCH) begin
            d.opcode           = inst[26] ? OP_BNE : OP_BEQ;
            d.rf_src1          = inst[9:5];
            d.rf_src2          = inst[4:0];
            d.imm              = offs16;
            d.is_branch        = 1'b1;
            d.branch_condition = 1'b1;
            d.branch_target    = pc + offs16;
        end else if ((inst & BRANCH_MASK) == B_MATCH || (inst & BRANCH_MASK) == BL_MATCH) begin
            d.opcode        = inst[26] ? OP_BL : OP_B;
            d.imm           = offs26;
            d.dest          = inst[26] ? 5'd1 : 5'd0;    // bl links to r1
            d.is_branch     = 1'b1;
            d.branch_taken  = 1'b1;
            d.branch_target = pc + offs26;
        end else if ((inst & BRANCH_MASK) == JIRL_MATCH) begin
            d.opcode        = OP_JIRL;
            d.rf_src1       = inst[9:5];
            d.imm           = offs16;
            d.dest          = inst[4:0];
            d.is_branch     = 1'b1;
            d.branch_taken  = 1'b1;
            d.is_jirl       = 1'b1;
            d.branch_target = offs16;    // Base register added later
        end else if ((inst & CSRRD_MASK) == CSRRD_MATCH) begin
            d.opcode      = OP_SPEC;
            d.src2_is_imm = 1'b1;
            d.imm         = 32'(inst[23:10]);
            d.dest        = inst[4:0];
            d.is_spec_op  = 1'b1;
            d.spec_opcode = SPEC_CSRRD;
        end else begin
            d.have_exception = 1'b1;
            d.exception_type = fetch_exc ? EXC_ADEF : EXC_INE;
        end
        uncond = d.is_branch && !d.branch_condition;
        d.branch_mistaken = (uncond && !pt) || (!d.is_branch && pt) ||
                            (uncond && !d.is_jirl && pt && ptgt != d.branch_target);
        return d;
    endfunction

    function automatic logic pairs_ref(input decoded_t a, input decoded_t b);
        logic raw;
        raw = a.dest != 5'd0 && (a.dest == b.rf_src1 || a.dest == b.rf_src2);
        return !a.is_spec_op && !raw && b.mem_type == MEM_NOP;
    endfunction

    // ########################################
    // Checks
    // ########################################

    task automatic check_decoded(input string name, input decoded_t got, input decoded_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic push(input logic [31:0] inst, input logic pt, input logic [31:0] ptgt,
                        input logic fetch_exc);
        exp_q.push_back(decode_ref(next_pc, inst, pt, ptgt, fetch_exc));
        push_valid              = 1'b1;
        push_pc                 = next_pc;
        push_inst               = inst;
        push_pred_branch_taken  = pt;
        push_pred_branch_target = ptgt;
        push_have_exception     = fetch_exc;
        push_exception_type     = fetch_exc ? EXC_ADEF : EXC_NONE;
        @(posedge clk);
        #2;
        push_valid  = 1'b0;
        next_pc     = next_pc + 32'd4;
        batch_count = batch_count + 1;
        total_pushed++;
        check_flag("fetch_full", fetch_full, batch_count >= QUEUE_DEPTH - 1);
    endtask

    // Release the held batch and wait until all of it has issued
    task automatic drain(input logic random_stall);
        logic [31:0] r;
        while (exp_q.size() != 0) begin
            r        = next_rand();
            ro_stall = random_stall && r[0];
            @(posedge clk);
            #2;
        end
        ro_stall    = 1'b1;
        batch_count = 0;
    endtask

    task automatic report(input string name);
        $display("test %s: %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    always @(posedge clk)
        loaded <= !ro_stall;    // Output register took new values at this edge

    always @(negedge clk) begin
        if (loaded && ro_b_valid && !ro_a_valid) begin
            errors++;
            $display("slot b issued without slot a at %0t", $time);
        end
        if (loaded && ro_a_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("instruction at pc %h issued with none left to expect", ro_a.pc);
            end else begin
                exp_a = exp_q.pop_front();
                pair  = exp_q.size() != 0 && pairs_ref(exp_a, exp_q[0]);
                check_decoded("ro_a", ro_a, exp_a);
                check_flag("ro_b_valid", ro_b_valid, pair);
                if (pair)
                    check_decoded("ro_b", ro_b, exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 200 + 4 * total_pushed) begin
            $display("timeout after %0d cycles, %0d instructions never issued",
                     cycles, exp_q.size());
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ########################################
    // Tests
    // ########################################

    initial begin
        logic [31:0] r;
        logic [31:0] inst;
        counter                 = COUNTER_VALUE;
        ro_stall                = 1'b1;
        push_valid              = 1'b0;
        push_pc                 = '0;
        push_inst               = '0;
        push_pred_branch_taken  = 1'b0;
        push_pred_branch_target = '0;
        push_have_exception     = 1'b0;
        push_exception_type     = EXC_NONE;
        @(negedge reset);

        for (int i = 0; i < 6; i++) begin    // Sources r0..r7, dests r10 and up
            r = next_rand();
            case (r[1:0])
                2'd0:    inst = encode(ADD_W_MATCH, {13'd0, r[4:2]}, {2'd0, r[7:5]}, 5'(10 + i));
                2'd1:    inst = encode(SUB_W_MATCH, {13'd0, r[4:2]}, {2'd0, r[7:5]}, 5'(10 + i));
                2'd2:    inst = encode(ADDI_W_MATCH, {4'd0, r[19:8]}, {2'd0, r[7:5]}, 5'(10 + i));
                default: inst = LU12I_W_MATCH | {7'd0, r[27:8], 5'(10 + i)};
            endcase
            push(inst, 1'b0, 32'd0, 1'b0);
        end
        drain(1'b0);
        report("independent alu");

        push(encode(ADD_W_MATCH, 16'd2, 5'd1, 5'd5), 1'b0, 32'd0, 1'b0);
        push(encode(ADD_W_MATCH, 16'd3, 5'd5, 5'd6), 1'b0, 32'd0, 1'b0);    // Reads r5
        push(encode(ADDI_W_MATCH, 16'h0ffc, 5'd2, 5'd20), 1'b0, 32'd0, 1'b0);
        push(encode(ADD_W_MATCH, 16'd2, 5'd1, 5'd0), 1'b0, 32'd0, 1'b0);
        push(encode(ADD_W_MATCH, 16'd0, 5'd0, 5'd7), 1'b0, 32'd0, 1'b0);    // r0 never blocks
        push(encode(ADDI_W_MATCH, 16'd9, 5'd9, 5'd8), 1'b0, 32'd0, 1'b0);
        push(encode(SUB_W_MATCH, 16'd8, 5'd11, 5'd10), 1'b0, 32'd0, 1'b0);
        drain(1'b0);
        report("raw hazard");

        push(encode(ADD_W_MATCH, 16'd2, 5'd1, 5'd12), 1'b0, 32'd0, 1'b0);
        push(encode(LD_W_MATCH, 16'd8, 5'd1, 5'd13), 1'b0, 32'd0, 1'b0);
        push(encode(ST_W_MATCH, 16'h0ff0, 5'd2, 5'd14), 1'b0, 32'd0, 1'b0);
        push(encode(ADD_W_MATCH, 16'd2, 5'd1, 5'd18), 1'b0, 32'd0, 1'b0);
        push(encode(CSRRD_MATCH, 16'h0010, 5'd0, 5'd15), 1'b0, 32'd0, 1'b0);
        push(encode(ADDI_W_MATCH, 16'd5, 5'd3, 5'd17), 1'b0, 32'd0, 1'b0);
        drain(1'b0);
        report("memory and csr");

        push(encode(BEQ_MATCH, 16'hfff0, 5'd1, 5'd2), 1'b0, 32'd0, 1'b0);
        push(encode(BNE_MATCH, 16'h0020, 5'd3, 5'd4), 1'b1, next_pc + 32'h80, 1'b0);
        push(encode(B_MATCH, 16'h0040, 5'd0, 5'd0), 1'b0, 32'd0, 1'b0);
        push(encode(BL_MATCH, 16'h0040, 5'd0, 5'd0), 1'b1, next_pc + 32'h100, 1'b0);
        push(encode(B_MATCH, 16'h0040, 5'h1f, 5'h1f), 1'b1, next_pc + 32'h100, 1'b0);
        push(encode(JIRL_MATCH, 16'h0010, 5'd1, 5'd3), 1'b1, 32'd0, 1'b0);
        push(encode(ADD_W_MATCH, 16'd2, 5'd1, 5'd9), 1'b1, next_pc + 32'h8, 1'b0);
        drain(1'b0);
        push(encode(RDCNTVL_MATCH, 16'd0, 5'd0, 5'd4), 1'b0, 32'd0, 1'b0);
        push(encode(RDCNTVH_MATCH, 16'd0, 5'd0, 5'd5), 1'b0, 32'd0, 1'b0);
        push(encode(JIRL_MATCH, 16'hfffc, 5'd6, 5'd0), 1'b0, 32'd0, 1'b0);
        drain(1'b0);
        report("branches and counters");

        push(encode(ADD_W_MATCH, 16'd2, 5'd1, 5'd3), 1'b0, 32'd0, 1'b1);
        push(32'hffff_ffff, 1'b0, 32'd0, 1'b1);
        push(encode(CSRRD_MATCH, 16'h0010, 5'd1, 5'd2), 1'b0, 32'd0, 1'b0);    // rj not zero
        for (int i = 0; i < 3; i++) begin
            r = next_rand();
            push({8'hff, r[23:0]}, r[24], 32'd0, 1'b0);
        end
        drain(1'b0);
        report("exceptions");

        for (int b = 0; b < 3; b++) begin
            for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
                r    = next_rand();
                inst = rand_inst(r);
                r    = next_rand();
                push(inst, r[0], r & 32'hffff_fffc, 1'b0);
            end
            drain(1'b1);
        end
        report("random stall");

        ro_stall = 1'b0;
        repeat (4) @(posedge clk);    // Anything issued now is extra
        #2;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
